//--- Makefile
# Verilator simulation of the pipelined CPU
VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  := CHECKS FAILED

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, fail on errors"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

$(BIN): $(FILELIST) $(wildcard rtl/*.sv tb/*.sv tb/*.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(BIN)
	@$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- rtl/cpu.sv
module cpu #(
    parameter int ROM_ADDR_W = 8
) (
    input  logic                  clock,
    input  logic                  rst_n,
    output logic [ROM_ADDR_W-1:0] rom_address,
    input  logic [31:0]           rom_data,
    output cpu_pkg::wb_master_t   wb_m,
    input  cpu_pkg::wb_slave_t    wb_s
);
    import cpu_pkg::*;

    if_id_t      if_id;
    id_ex_t      id_ex;
    ex_mem_t     ex_mem;
    mem_wb_t     mem_wb;

    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] rs1_value;
    logic [31:0] rs2_value;

    logic        branch_taken;
    logic [31:0] branch_target;
    logic        mem_busy;

    logic        hold_front;
    logic        bubble_ex;
    logic        flush_front;
    logic        hold_ex;

    fetch #(.ROM_ADDR_W(ROM_ADDR_W)) u_fetch (
        .clk(clock), .rst_n(rst_n),
        .hold_front(hold_front), .flush_front(flush_front),
        .branch_target(branch_target),
        .rom_data(rom_data), .rom_address(rom_address),
        .if_id(if_id)
    );

    decode u_decode (
        .clk(clock), .rst_n(rst_n),
        .hold_front(hold_front), .bubble_ex(bubble_ex),
        .flush_front(flush_front), .hold_ex(hold_ex),
        .if_id(if_id),
        .rs1(rs1), .rs2(rs2),
        .rs1_value(rs1_value), .rs2_value(rs2_value),
        .id_ex(id_ex)
    );

    register_bank u_register_bank (
        .clk(clock),
        .rd_addr1(rs1), .rd_addr2(rs2),
        .value1(rs1_value), .value2(rs2_value),
        .mem_wb(mem_wb) // Writeback port
    );

    execute u_execute (
        .clk(clock), .rst_n(rst_n), .hold_ex(hold_ex),
        .id_ex(id_ex), .mem_wb(mem_wb), .ex_mem(ex_mem),
        .branch_taken(branch_taken), .branch_target(branch_target)
    );

    mem_access u_mem_access (
        .clk(clock), .rst_n(rst_n),
        .ex_mem(ex_mem), .wb_m(wb_m), .wb_s(wb_s),
        .mem_busy(mem_busy), .mem_wb(mem_wb)
    );

    hazard_control u_hazard_control (
        .decode_rs1(rs1), .decode_rs2(rs2), .id_ex(id_ex),
        .branch_taken(branch_taken), .mem_busy(mem_busy),
        .hold_front(hold_front), .bubble_ex(bubble_ex),
        .flush_front(flush_front), .hold_ex(hold_ex)
    );

endmodule

//--- rtl/cpu_pkg.sv
package cpu_pkg;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_e;

    // Control bits, travel with the instruction
    typedef struct packed {
        logic       reg_write;
        logic       mem_read;
        logic       mem_write;
        logic       branch;
        logic       branch_ne;   // BNE instead of BEQ
        logic       alu_src_imm; // Second operand from imm
        alu_op_e    alu_op;
        logic [4:0] rd;
    } ctrl_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
    } if_id_t;

    typedef struct packed {
        logic        valid;
        ctrl_t       ctrl;
        logic [31:0] pc;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] rs1_value;
        logic [31:0] rs2_value;
        logic [31:0] imm;
    } id_ex_t;

    typedef struct packed {
        logic        valid;
        ctrl_t       ctrl;
        logic [31:0] result;     // ALU result or data address
        logic [31:0] store_data;
    } ex_mem_t;

    // Register bank write port
    typedef struct packed {
        logic        reg_write;
        logic [4:0]  rd;
        logic [31:0] value;
    } mem_wb_t;

    typedef struct packed {
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
        logic        we;
        logic        cyc;
        logic        stb;
    } wb_master_t;

    typedef struct packed {
        logic [31:0] dat;
        logic        ack;
    } wb_slave_t;

    localparam logic [31:0] NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0

endpackage

//--- rtl/decode.sv
module decode (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            hold_front,
    input  logic            bubble_ex,
    input  logic            flush_front,
    input  logic            hold_ex,
    input  cpu_pkg::if_id_t if_id,
    output logic [4:0]      rs1,
    output logic [4:0]      rs2,
    input  logic [31:0]     rs1_value,
    input  logic [31:0]     rs2_value,
    output cpu_pkg::id_ex_t id_ex
);
    import cpu_pkg::*;

    logic [31:0] instr;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic        use_rs1;
    logic        use_rs2;
    logic [31:0] imm;
    ctrl_t       ctrl;

    assign instr  = if_id.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        ctrl    = '0;
        imm     = '0;
        use_rs1 = 1'b1;
        use_rs2 = 1'b0;
        case (opcode)
            OPC_OP: begin
                ctrl.reg_write = 1'b1;
                use_rs2        = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b010:  ctrl.alu_op = ALU_SLT;
                    3'b100:  ctrl.alu_op = ALU_XOR;
                    3'b110:  ctrl.alu_op = ALU_OR;
                    3'b111:  ctrl.alu_op = ALU_AND;
                    default: ctrl.reg_write = 1'b0; // Shifts, SLTU
                endcase
                if (funct7 != 7'b0 && !(funct7 == 7'b0100000 && funct3 == 3'b000)) begin
                    ctrl.reg_write = 1'b0;
                end
            end
            OPC_OP_IMM: begin
                ctrl.reg_write   = (funct3 == 3'b000); // ADDI only
                ctrl.alu_src_imm = 1'b1;
                imm              = {{20{instr[31]}}, instr[31:20]};
            end
            OPC_LOAD: begin
                ctrl.reg_write   = (funct3 == 3'b010); // LW only
                ctrl.mem_read    = (funct3 == 3'b010);
                ctrl.alu_src_imm = 1'b1;
                imm              = {{20{instr[31]}}, instr[31:20]};
            end
            OPC_STORE: begin
                ctrl.mem_write   = (funct3 == 3'b010);
                ctrl.alu_src_imm = 1'b1;
                use_rs2          = 1'b1;
                imm              = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            OPC_BRANCH: begin
                ctrl.branch    = (funct3[2:1] == 2'b00); // BEQ and BNE
                ctrl.branch_ne = funct3[0];
                use_rs2        = 1'b1;
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            default: ctrl = '0;
        endcase
        if (!(ctrl.reg_write || ctrl.mem_write || ctrl.branch)) begin
            use_rs1 = 1'b0; // No-op reads nothing
            use_rs2 = 1'b0;
        end
        ctrl.rd = ctrl.reg_write ? instr[11:7] : 5'd0;
    end

    assign rs1 = use_rs1 ? instr[19:15] : 5'd0;
    assign rs2 = use_rs2 ? instr[24:20] : 5'd0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ex.valid <= 1'b0;
            id_ex.ctrl  <= '0;
        end else if (!hold_ex) begin
            // A held front presents the same word again next cycle
            if (bubble_ex || flush_front || hold_front || !if_id.valid) begin
                id_ex.valid <= 1'b0;
                id_ex.ctrl  <= '0;
            end else begin
                id_ex.valid <= 1'b1;
                id_ex.ctrl  <= ctrl;
            end
            id_ex.pc        <= if_id.pc;
            id_ex.rs1       <= rs1;
            id_ex.rs2       <= rs2;
            id_ex.rs1_value <= rs1_value;
            id_ex.rs2_value <= rs2_value;
            id_ex.imm       <= imm;
        end
    end

    a_bubble_inert: assert property (@(posedge clk) disable iff (!rst_n)
        !id_ex.valid |-> (id_ex.ctrl == '0));

endmodule

//--- rtl/execute.sv
module execute (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             hold_ex,
    input  cpu_pkg::id_ex_t  id_ex,
    input  cpu_pkg::mem_wb_t mem_wb,
    output cpu_pkg::ex_mem_t ex_mem,
    output logic             branch_taken,
    output logic [31:0]      branch_target
);
    import cpu_pkg::*;

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_b;
    logic [31:0] alu_result;
    mem_wb_t     retired; // Latest write already in the bank

    // Youngest producer wins
    function automatic logic [31:0] pick(input logic [4:0] src, input logic [31:0] fallback,
                                         input ex_mem_t em, input mem_wb_t mw, input mem_wb_t rt);
        logic [31:0] value;
        value = fallback;
        if (src != 5'd0) begin
            if (em.valid && em.ctrl.reg_write && !em.ctrl.mem_read && em.ctrl.rd == src) begin
                value = em.result;
            end else if (mw.reg_write && mw.rd == src) begin
                value = mw.value;
            end else if (rt.reg_write && rt.rd == src) begin
                value = rt.value; // Retired while this stage was frozen
            end
        end
        return value;
    endfunction

    assign op_a  = pick(id_ex.rs1, id_ex.rs1_value, ex_mem, mem_wb, retired);
    assign op_b  = pick(id_ex.rs2, id_ex.rs2_value, ex_mem, mem_wb, retired);
    assign alu_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : op_b;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_SUB: alu_result = op_a - alu_b;
            ALU_AND: alu_result = op_a & alu_b;
            ALU_OR:  alu_result = op_a | alu_b;
            ALU_XOR: alu_result = op_a ^ alu_b;
            ALU_SLT: alu_result = {31'd0, $signed(op_a) < $signed(alu_b)};
            default: alu_result = op_a + alu_b; // ADD and addresses
        endcase
    end

    assign branch_taken  = id_ex.valid && id_ex.ctrl.branch &&
                           (id_ex.ctrl.branch_ne ^ (op_a == op_b));
    assign branch_target = id_ex.pc + id_ex.imm;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retired.reg_write <= 1'b0;
        end else if (mem_wb.reg_write) begin
            retired <= mem_wb;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mem.valid <= 1'b0;
            ex_mem.ctrl  <= '0;
        end else if (!hold_ex) begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.ctrl       <= id_ex.ctrl;
            ex_mem.result     <= alu_result;
            ex_mem.store_data <= op_b;
        end
    end

endmodule

//--- rtl/fetch.sv
module fetch #(
    parameter int ROM_ADDR_W = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  hold_front,
    input  logic                  flush_front,
    input  logic [31:0]           branch_target,
    input  logic [31:0]           rom_data,
    output logic [ROM_ADDR_W-1:0] rom_address,
    output cpu_pkg::if_id_t       if_id
);
    import cpu_pkg::*;

    logic [31:0] pc;

    assign rom_address = pc[ROM_ADDR_W+1:2]; // Word index

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc          <= '0;
            if_id.valid <= 1'b0;
            if_id.instr <= NOP_INSTR;
        end else if (flush_front) begin
            // Word on rom_data is the second discarded instruction
            pc          <= branch_target;
            if_id.valid <= 1'b0;
            if_id.pc    <= pc;
            if_id.instr <= NOP_INSTR;
        end else if (!hold_front) begin
            pc          <= pc + 32'd4;
            if_id.valid <= 1'b1;
            if_id.pc    <= pc;
            if_id.instr <= rom_data;
        end
    end

    // A redirect is never swallowed by a hold
    a_flush_not_held: assert property (@(posedge clk) disable iff (!rst_n)
        flush_front |-> !hold_front);

endmodule

//--- rtl/hazard_control.sv
module hazard_control (
    input  logic            [4:0] decode_rs1,
    input  logic            [4:0] decode_rs2,
    input  cpu_pkg::id_ex_t       id_ex,
    input  logic                  branch_taken,
    input  logic                  mem_busy,
    output logic                  hold_front,
    output logic                  bubble_ex,
    output logic                  flush_front,
    output logic                  hold_ex
);
    logic load_in_ex;
    logic load_use;
    logic redirect;

    assign load_in_ex = id_ex.valid && id_ex.ctrl.mem_read && (id_ex.ctrl.rd != 5'd0);
    assign load_use   = load_in_ex &&
                        (id_ex.ctrl.rd == decode_rs1 || id_ex.ctrl.rd == decode_rs2);

    // Branch waits in execute while the bus is busy
    assign redirect = branch_taken && !mem_busy;

    assign hold_ex     = mem_busy;
    assign flush_front = redirect;
    assign bubble_ex   = !mem_busy && !redirect && load_use;
    assign hold_front  = mem_busy || bubble_ex;

endmodule

//--- rtl/mem_access.sv
module mem_access (
    input  logic                clk,
    input  logic                rst_n,
    input  cpu_pkg::ex_mem_t    ex_mem,
    output cpu_pkg::wb_master_t wb_m,
    input  cpu_pkg::wb_slave_t  wb_s,
    output logic                mem_busy,
    output cpu_pkg::mem_wb_t    mem_wb
);
    logic request;

    assign request = ex_mem.valid && (ex_mem.ctrl.mem_read || ex_mem.ctrl.mem_write);

    // Request follows ex_mem, which stays frozen until ack
    always_comb begin
        wb_m.adr = ex_mem.result;
        wb_m.dat = ex_mem.store_data;
        wb_m.sel = 4'hf; // Word accesses only
        wb_m.we  = ex_mem.ctrl.mem_write;
        wb_m.cyc = request;
        wb_m.stb = request;
    end

    assign mem_busy = request && !wb_s.ack;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_wb.reg_write <= 1'b0;
        end else begin
            mem_wb.reg_write <= ex_mem.valid && ex_mem.ctrl.reg_write && !mem_busy;
        end
        mem_wb.rd    <= ex_mem.ctrl.rd;
        mem_wb.value <= ex_mem.ctrl.mem_read ? wb_s.dat : ex_mem.result;
    end

    a_stable_request: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_m.stb && !wb_s.ack) |=>
            wb_m.stb && $stable(wb_m.adr) && $stable(wb_m.we) && $stable(wb_m.dat));

    // Slave must not answer an idle bus
    a_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_s.ack |-> wb_m.cyc);

endmodule

//--- rtl/register_bank.sv
module register_bank (
    input  logic             clk,
    input  logic [4:0]       rd_addr1,
    input  logic [4:0]       rd_addr2,
    output logic [31:0]      value1,
    output logic [31:0]      value2,
    input  cpu_pkg::mem_wb_t mem_wb
);
    logic [31:0] regs [1:31]; // x0 has no storage
    logic        writing;
    logic        bypass1;
    logic        bypass2;

    assign writing = mem_wb.reg_write && (mem_wb.rd != 5'd0);

    always_ff @(posedge clk) begin
        if (writing) begin
            regs[mem_wb.rd] <= mem_wb.value;
        end
    end

    // Value written this cycle is visible to decode now
    assign bypass1 = writing && (rd_addr1 == mem_wb.rd);
    assign bypass2 = writing && (rd_addr2 == mem_wb.rd);

    assign value1 = (rd_addr1 == 5'd0) ? 32'd0 :
                    bypass1            ? mem_wb.value : regs[rd_addr1];
    assign value2 = (rd_addr2 == 5'd0) ? 32'd0 :
                    bypass2            ? mem_wb.value : regs[rd_addr2];

endmodule

//--- sim.f
+incdir+tb
rtl/cpu_pkg.sv
rtl/fetch.sv
rtl/decode.sv
rtl/register_bank.sv
rtl/execute.sv
rtl/mem_access.sv
rtl/hazard_control.sv
rtl/cpu.sv
tb/tb_cpu.sv

//--- tb/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

localparam int BODY_LEN = 56; // Random instructions between prologue and dump

logic [31:0] rom [0:255];
logic [31:0] model_mem [0:63];
logic [31:0] exp_adr [$];
logic [31:0] exp_dat [$];
logic [31:0] end_pc; // Address of the final branch-to-self
int          gen_pc;

function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
endfunction

// SW data, imm(base)
function automatic logic [31:0] s_type(input logic [4:0] base, input logic [4:0] src,
                                       input logic [11:0] imm);
    return {imm[11:5], src, base, 3'b010, imm[4:0], OPC_STORE};
endfunction

function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                       input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
endfunction

function automatic void emit(input logic [31:0] word);
    rom[gen_pc] = word;
    gen_pc++;
endfunction

function automatic logic [31:0] random_alu(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
    case (rand_bits(3) % 6)
        0:       return r_type(7'h20, 3'b000, rd, rs1, rs2); // SUB
        1:       return r_type(7'h00, 3'b111, rd, rs1, rs2); // AND
        2:       return r_type(7'h00, 3'b110, rd, rs1, rs2); // OR
        3:       return r_type(7'h00, 3'b100, rd, rs1, rs2); // XOR
        4:       return r_type(7'h00, 3'b010, rd, rs1, rs2); // SLT
        default: return r_type(7'h00, 3'b000, rd, rs1, rs2); // ADD
    endcase
endfunction

// Mode 0 ALU only, 1 load heavy, 2 branch heavy, 3 everything
function automatic void make_program(input int mode);
    logic [31:0] kind;
    logic [4:0]  rd;
    logic [4:0]  src;
    logic [12:0] off;
    for (int i = 0; i < 256; i++) begin
        rom[i] = NOP_INSTR;
    end
    gen_pc = 0;
    for (int r = 1; r < 32; r++) begin
        emit(i_type(OPC_OP_IMM, 3'b000, 5'(r), 5'd0, 12'(rand_bits(12))));
    end
    while (gen_pc < 31 + BODY_LEN) begin
        kind = rand_bits(3);
        rd   = 5'(rand_bits(5));
        src  = 5'(rand_bits(5));
        kind = (mode == 0 && kind > 4) ? 32'd0 : kind;
        kind = (mode == 1 && kind > 5) ? 32'd5 : kind;
        kind = (mode == 2 && (kind == 5 || kind == 7)) ? 32'd6 : kind;
        kind = (kind == 6 && gen_pc > 28 + BODY_LEN) ? 32'd4 : kind; // Keep targets in the body
        case (kind)
            3: emit(i_type(OPC_OP_IMM, 3'b000, rd, src, 12'(rand_bits(12))));
            4: emit(s_type(5'd0, src, {5'd0, 5'(rand_bits(5)), 2'b00}));
            5: begin
                emit(i_type(OPC_LOAD, 3'b010, rd, 5'd0, {5'd0, 5'(rand_bits(5)), 2'b00}));
                emit(random_alu(5'(rand_bits(5)), rd, src)); // Uses the load at once
            end
            6: begin
                off = (rand_bits(1) == 32'd1) ? 13'd12 : 13'd8;
                emit(b_type((rand_bits(1) == 32'd1) ? 3'b001 : 3'b000, src,
                            (rand_bits(1) == 32'd1) ? src : rd, off));
            end
            7: emit(i_type(OPC_OP_IMM, 3'b110, rd, src, 12'(rand_bits(12)))); // ORI, no-op here
            default: emit(random_alu(rd, src, 5'(rand_bits(5))));
        endcase
    end
    for (int r = 0; r < 32; r++) begin
        emit(s_type(5'd0, 5'(r), 12'(128 + 4 * r))); // Register dump into words 32 to 63
    end
    end_pc = 32'(gen_pc * 4);
    emit(b_type(3'b000, 5'd0, 5'd0, 13'd0));
endfunction

// Instruction-level run of rom, fills the expected store list
function automatic void model_program();
    logic [31:0] regs [0:31];
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] addr;
    logic [31:0] value;
    logic        wr;
    int          steps;
    for (int i = 0; i < 32; i++) begin
        regs[i] = '0;
    end
    for (int i = 0; i < 64; i++) begin
        model_mem[i] = fill_word(i);
    end
    exp_adr.delete();
    exp_dat.delete();
    pc    = '0;
    steps = 0;
    while (pc != end_pc && steps < 2000) begin
        w       = rom[pc[9:2]];
        a       = regs[w[19:15]];
        b       = regs[w[24:20]];
        next_pc = pc + 32'd4;
        wr      = 1'b0;
        value   = '0;
        case (w[6:0])
            OPC_OP: begin
                wr = 1'b1;
                case ({w[31:25], w[14:12]})
                    10'h000: value = a + b;
                    10'h100: value = a - b;
                    10'h002: value = {31'd0, $signed(a) < $signed(b)};
                    10'h004: value = a ^ b;
                    10'h006: value = a | b;
                    10'h007: value = a & b;
                    default: wr = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                wr    = (w[14:12] == 3'b000);
                value = a + {{20{w[31]}}, w[31:20]};
            end
            OPC_LOAD: begin
                addr  = a + {{20{w[31]}}, w[31:20]};
                wr    = (w[14:12] == 3'b010);
                value = model_mem[addr[7:2]];
            end
            OPC_STORE: begin
                addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                if (w[14:12] == 3'b010) begin
                    model_mem[addr[7:2]] = b;
                    exp_adr.push_back(addr);
                    exp_dat.push_back(b);
                end
            end
            OPC_BRANCH: begin
                if ((w[14:12] == 3'b000 && a == b) || (w[14:12] == 3'b001 && a != b)) begin
                    next_pc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                end
            end
            default: wr = 1'b0;
        endcase
        if (wr && w[11:7] != 5'd0) begin
            regs[w[11:7]] = value;
        end
        pc = next_pc;
        steps++;
    end
endfunction

`endif

//--- tb/tb_cpu.sv
module tb_cpu;
    timeunit 1ns;
    timeprecision 100ps;
    import cpu_pkg::*;

    localparam int ROM_ADDR_W    = 8;
    localparam int STORE_TIMEOUT = 400; // Cycles without a store before giving up

    logic                  clock;
    logic                  rst_n;
    logic [ROM_ADDR_W-1:0] rom_address;
    logic [31:0]           rom_data;
    wb_master_t            wb_m;
    wb_slave_t             wb_s;

    logic [31:0] lfsr_state;
    logic [31:0] data_mem [0:63];
    logic [31:0] req_adr;
    logic        pending;     // Access seen, not yet acknowledged
    int          wait_left;
    int          max_wait;
    int          store_count;
    int          errors;
    int          checks;
    int          tests;
    int          failed_tests;

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits       = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    // Initial data memory contents
    function automatic logic [31:0] fill_word(input int index);
        return (32'(index) * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
    endfunction

    `include "tb_ref_model.svh"

    cpu #(.ROM_ADDR_W(ROM_ADDR_W)) UUT (
        .clock(clock), .rst_n(rst_n),
        .rom_address(rom_address), .rom_data(rom_data),
        .wb_m(wb_m), .wb_s(wb_s)
    );

    assign rom_data = rom[rom_address]; // Combinational ROM

    always #20 clock = ~clock;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        assert (got === expected) else begin
            $display("MISMATCH %s: got %h, expected %h", name, got, expected);
            errors++;
        end
    endtask

    task automatic expect_true(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            $display("ERROR: %s", what);
            errors++;
        end
    endtask

    // Completes the access with ack held across the next rising edge
    task automatic serve_access();
        logic [5:0] idx;
        idx      = wb_m.adr[7:2];
        pending  = 1'b0;
        wb_s.ack = 1'b1;
        expect_true(wb_m.adr[31:8] == '0 && wb_m.adr[1:0] == 2'b00,
                    "access outside the data memory");
        check_value("wb_m.sel", 32'(wb_m.sel), 32'h0000_000f); // Word accesses only
        if (wb_m.we) begin
            data_mem[idx] = wb_m.dat;
            if (store_count < exp_adr.size()) begin
                check_value("wb_m.adr", wb_m.adr, exp_adr[store_count]);
                check_value("wb_m.dat", wb_m.dat, exp_dat[store_count]);
            end else begin
                expect_true(1'b0, "store arrived beyond the expected list");
            end
            store_count++;
        end else begin
            wb_s.dat = data_mem[idx];
        end
    endtask

    // Wishbone slave, 0 to max_wait wait states per access
    always @(negedge clock) begin
        wb_s.ack = 1'b0;
        if (!rst_n) begin
            pending = 1'b0;
        end else if (pending && !(wb_m.cyc && wb_m.stb)) begin
            expect_true(1'b0, "cyc or stb dropped before the acknowledge");
            pending = 1'b0;
        end else if (wb_m.cyc && wb_m.stb) begin
            if (!pending) begin
                pending   = 1'b1;
                req_adr   = wb_m.adr;
                wait_left = (max_wait == 0) ? 0 : int'(rand_bits(2)) % (max_wait + 1);
            end
            check_value("wb_m.adr", wb_m.adr, req_adr);
            if (wait_left > 0) begin
                wait_left--;
            end else begin
                serve_access();
            end
        end
    end

    task automatic reset_dut();
        @(negedge clock);
        rst_n = 1'b0;
        repeat (10) @(negedge clock);
        check_value("rom_address", 32'(rom_address), 32'd0);
        expect_true(!wb_m.cyc && !wb_m.stb, "cyc or stb high during reset");
        for (int i = 0; i < 64; i++) begin
            data_mem[i] = fill_word(i);
        end
        store_count = 0;
        rst_n       = 1'b1;
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("test %s: ok, %0d stores", name, store_count);
        end else begin
            failed_tests++;
            $display("test %s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    // Reset while a program is partly through the pipeline
    task automatic mid_run_reset();
        int errors_before;
        errors_before = errors;
        make_program(3);
        model_program();
        max_wait = 1;
        reset_dut();
        repeat (30) @(negedge clock);
        reset_dut();
        report_test("reset_state", errors_before);
    endtask

    task automatic run_test(input string name, input int mode, input int waits);
        int errors_before;
        int idle;
        int last;
        errors_before = errors;
        make_program(mode);
        model_program();
        max_wait = waits;
        reset_dut();
        idle = 0;
        while (store_count < exp_adr.size() && idle < STORE_TIMEOUT) begin
            last = store_count;
            @(negedge clock);
            idle = (store_count == last) ? idle + 1 : 0;
        end
        expect_true(idle < STORE_TIMEOUT,
                    $sformatf("no store arrived before the timeout, %0d of %0d seen",
                              store_count, exp_adr.size()));
        idle = 0;
        while (idle < 24) begin // Stray stores after the dump are flagged
            @(negedge clock);
            idle++;
        end
        report_test(name, errors_before);
    endtask

    initial begin
        clock        = 1'b0;
        rst_n        = 1'b0;
        wb_s         = '0;
        lfsr_state   = 32'h9e8bb935;
        pending      = 1'b0;
        wait_left    = 0;
        max_wait     = 0;
        store_count  = 0;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        failed_tests = 0;
        mid_run_reset();
        run_test("alu_forwarding", 0, 0);
        run_test("load_use", 1, 0);
        run_test("branches", 2, 0);
        run_test("back_pressure", 3, 3);
        for (int i = 0; i < 8; i++) begin
            run_test($sformatf("random_%0d", i), 3, 3);
        end
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
